/* rtl/rtn_xbar_consts.svh */
`ifndef RTN_XBAR_CONSTS_SVH
`define RTN_XBAR_CONSTS_SVH

// ==================================================
// Crossbar dimensions
// ==================================================
`define RTN_BANK_NUM    4
`define RTN_CH_NUM      3

// Per-bank ring, seven slots usable
`define RTN_DEPTH       8
`define RTN_PTR_W       3

// Response payload
`define RTN_DATA_W      16

`endif

/* rtl/rtn_xbar_pkg.sv */
`include "rtn_xbar_consts.svh"

package rtn_xbar_pkg;

    // ==================================================
    // Response types
    // ==================================================

    // Opcode returned by a bank
    typedef enum logic [1:0] {
        RSP_RD_DATA = 2'd0,
        RSP_WR_ACK  = 2'd1,
        RSP_ERR     = 2'd2
    } rsp_op_e;

    // One buffered response
    typedef struct packed {
        rsp_op_e                op;
        logic [`RTN_DATA_W-1:0] data;
    } rtn_rsp_t;

endpackage

/* rtl/rtn_head_if.sv */
`timescale 1ns/1ps
`include "rtn_xbar_consts.svh"

interface rtn_head_if
    import rtn_xbar_pkg::*;
();

    // Ring pointers per bank
    logic [`RTN_BANK_NUM-1:0][`RTN_PTR_W-1:0]  w_ptr;
    logic [`RTN_BANK_NUM-1:0][`RTN_PTR_W-1:0]  r_ptr;

    // Head entry of each bank
    logic [`RTN_BANK_NUM-1:0]                  head_valid;
    rtn_rsp_t [`RTN_BANK_NUM-1:0]              head;

    // High in the retire cycle
    logic [`RTN_BANK_NUM-1:0]                  head_adv;

    // Set once a channel has taken the current head
    logic [`RTN_BANK_NUM-1:0][`RTN_CH_NUM-1:0] pop_done;

    // Ring storage and pointer logic
    modport provider (
        output w_ptr,
        output r_ptr,
        output head_valid,
        output head,
        output head_adv,
        input  pop_done
    );

    // Channel delivery
    modport consumer (
        input  head_valid,
        input  head,
        input  head_adv,
        output pop_done
    );

endinterface

/* rtl/rtn_xbar_entry_ram.sv */
`timescale 1ns/1ps
`include "rtn_xbar_consts.svh"

module rtn_xbar_entry_ram
    import rtn_xbar_pkg::*;
(
    input  logic                                       clk,
    input  logic                                       rst_n,

    input  logic [`RTN_BANK_NUM-1:0]                   bank_rsp_valid,
    input  logic [`RTN_BANK_NUM-1:0]                   bank_rsp_ready,
    input  rsp_op_e [`RTN_BANK_NUM-1:0]                bank_rsp_op,
    input  logic [`RTN_BANK_NUM-1:0][`RTN_DATA_W-1:0]  bank_rsp_data,

    rtn_head_if.provider                               head_bus
);

    logic [`RTN_BANK_NUM-1:0] wr_en;
    rtn_rsp_t                 mem [`RTN_BANK_NUM][`RTN_DEPTH];

    assign wr_en = bank_rsp_valid & bank_rsp_ready;

    // ==================================================
    // Ring write
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int b = 0; b < `RTN_BANK_NUM; b++) begin
                for (int s = 0; s < `RTN_DEPTH; s++) begin
                    mem[b][s] <= '0;
                end
            end
        end else begin
            for (int b = 0; b < `RTN_BANK_NUM; b++) begin
                // Slot at w_ptr takes the accepted response
                if (wr_en[b]) begin
                    mem[b][head_bus.w_ptr[b]] <= '{op: bank_rsp_op[b], data: bank_rsp_data[b]};
                end
            end
        end
    end

    // ==================================================
    // Head read
    // ==================================================

    // Oldest entry sits at r_ptr, visible right after the write edge
    always_comb begin
        for (int b = 0; b < `RTN_BANK_NUM; b++) begin
            head_bus.head[b] = mem[b][head_bus.r_ptr[b]];
        end
    end

endmodule

/* rtl/rtn_xbar_ptr_gen.sv */
`timescale 1ns/1ps
`include "rtn_xbar_consts.svh"

module rtn_xbar_ptr_gen
    import rtn_xbar_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,

    input  logic [`RTN_BANK_NUM-1:0] bank_rsp_valid,
    output logic [`RTN_BANK_NUM-1:0] bank_rsp_ready,

    rtn_head_if.provider             head_bus
);

    // One pointer pair and counter per bank
    for (genvar b = 0; b < `RTN_BANK_NUM; b++) begin : g_bank
        rtn_xbar_sub_ptr_gen u_sub_ptr_gen (
            .clk        (clk),
            .rst_n      (rst_n),
            .rsp_valid  (bank_rsp_valid[b]),
            .rsp_ready  (bank_rsp_ready[b]),
            .pop_done   (head_bus.pop_done[b]),
            .w_ptr      (head_bus.w_ptr[b]),
            .r_ptr      (head_bus.r_ptr[b]),
            .head_valid (head_bus.head_valid[b]),
            .head_adv   (head_bus.head_adv[b])
        );
    end

endmodule

module rtn_xbar_sub_ptr_gen
    import rtn_xbar_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,

    input  logic                   rsp_valid,
    output logic                   rsp_ready,

    input  logic [`RTN_CH_NUM-1:0] pop_done,

    output logic [`RTN_PTR_W-1:0]  w_ptr,
    output logic [`RTN_PTR_W-1:0]  r_ptr,
    output logic                   head_valid,
    output logic                   head_adv
);

    logic                  push;
    logic                  retire;

    logic [`RTN_PTR_W-1:0] w_ptr_r;
    logic [`RTN_PTR_W-1:0] r_ptr_r;

    logic [`RTN_PTR_W-1:0] used_cnt;
    logic [`RTN_PTR_W-1:0] used_cnt_nxt;

    assign push   = rsp_valid & rsp_ready;

    // Head leaves once every channel has it
    assign retire = (|used_cnt) & (&pop_done);

    // ==================================================
    // Pointers
    // ==================================================

    // Both wrap naturally over the eight slots
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            w_ptr_r <= '0;
        end else if (push) begin
            w_ptr_r <= w_ptr_r + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_ptr_r <= '0;
        end else if (retire) begin
            r_ptr_r <= r_ptr_r + 1'b1;
        end
    end

    // ==================================================
    // Occupancy
    // ==================================================
    always_comb begin
        case ({push, retire})
            2'b10:   used_cnt_nxt = used_cnt + 1'b1;
            2'b01:   used_cnt_nxt = used_cnt - 1'b1;
            // push and retire together, count unchanged
            default: used_cnt_nxt = used_cnt;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            used_cnt <= '0;
        end else begin
            used_cnt <= used_cnt_nxt;
        end
    end

    // Full at seven entries
    assign rsp_ready  = ~(&used_cnt);
    assign head_valid = |used_cnt;
    assign head_adv   = retire;

    assign w_ptr = w_ptr_r;
    assign r_ptr = r_ptr_r;

endmodule

/* rtl/rtn_xbar_ch_deliver.sv */
`timescale 1ns/1ps
`include "rtn_xbar_consts.svh"

module rtn_xbar_ch_deliver
    import rtn_xbar_pkg::*;
(
    input  logic                                             clk,
    input  logic                                             rst_n,

    input  logic [`RTN_CH_NUM-1:0]                           ch_stall,

    rtn_head_if.consumer                                     head_bus,

    output logic [`RTN_CH_NUM-1:0]                           ch_valid,
    output logic [`RTN_CH_NUM-1:0][$clog2(`RTN_BANK_NUM)-1:0] ch_bank,
    output rsp_op_e [`RTN_CH_NUM-1:0]                        ch_op,
    output logic [`RTN_CH_NUM-1:0][`RTN_DATA_W-1:0]          ch_data
);

    // Last bank served per channel
    logic [`RTN_CH_NUM-1:0][$clog2(`RTN_BANK_NUM)-1:0] rr_ptr;

    logic [`RTN_CH_NUM-1:0]                            sel_vld;
    logic [`RTN_CH_NUM-1:0][$clog2(`RTN_BANK_NUM)-1:0] sel_bank;

    logic [`RTN_BANK_NUM-1:0][`RTN_CH_NUM-1:0]         pop_done_r;

    // ==================================================
    // Round-robin select
    // ==================================================

    // Search starts one past the last bank served, wraps back to it
    always_comb begin : rr_search
        logic [$clog2(`RTN_BANK_NUM)-1:0] idx;

        idx      = '0;
        sel_vld  = '0;
        sel_bank = rr_ptr;
        for (int c = 0; c < `RTN_CH_NUM; c++) begin
            for (int i = 1; i <= `RTN_BANK_NUM; i++) begin
                idx = rr_ptr[c] + i[$clog2(`RTN_BANK_NUM)-1:0];
                if (!sel_vld[c] && !ch_stall[c] &&
                    head_bus.head_valid[idx] && !pop_done_r[idx][c]) begin
                    sel_vld[c]  = 1'b1;
                    sel_bank[c] = idx;
                end
            end
        end
    end

    // ==================================================
    // Pop flags
    // ==================================================

    // Set on take, cleared when the head retires
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pop_done_r <= '0;
        end else begin
            for (int b = 0; b < `RTN_BANK_NUM; b++) begin
                for (int c = 0; c < `RTN_CH_NUM; c++) begin
                    if (head_bus.head_adv[b]) begin
                        pop_done_r[b][c] <= 1'b0;
                    end else if (sel_vld[c] && (sel_bank[c] == b)) begin
                        pop_done_r[b][c] <= 1'b1;
                    end
                end
            end
        end
    end

    assign head_bus.pop_done = pop_done_r;

    // ==================================================
    // Channel outputs
    // ==================================================

    // Start at the top bank so bank 0 is searched first
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ch_valid <= '0;
            rr_ptr   <= '1;
        end else begin
            ch_valid <= sel_vld;
            for (int c = 0; c < `RTN_CH_NUM; c++) begin
                if (sel_vld[c]) begin
                    rr_ptr[c] <= sel_bank[c];
                end
            end
        end
    end

    // Payload held until the next take
    always_ff @(posedge clk) begin
        for (int c = 0; c < `RTN_CH_NUM; c++) begin
            if (sel_vld[c]) begin
                ch_bank[c] <= sel_bank[c];
                ch_op[c]   <= head_bus.head[sel_bank[c]].op;
                ch_data[c] <= head_bus.head[sel_bank[c]].data;
            end
        end
    end

endmodule

/* rtl/rtn_xbar.sv */
`timescale 1ns/1ps
`include "rtn_xbar_consts.svh"

module rtn_xbar
    import rtn_xbar_pkg::*;
(
    input  logic                                             clk,
    input  logic                                             rst_n,

    // Bank response inputs
    input  logic [`RTN_BANK_NUM-1:0]                         bank_rsp_valid,
    output logic [`RTN_BANK_NUM-1:0]                         bank_rsp_ready,
    input  rsp_op_e [`RTN_BANK_NUM-1:0]                      bank_rsp_op,
    input  logic [`RTN_BANK_NUM-1:0][`RTN_DATA_W-1:0]        bank_rsp_data,

    // Channel outputs, one-cycle strobe
    input  logic [`RTN_CH_NUM-1:0]                           ch_stall,
    output logic [`RTN_CH_NUM-1:0]                           ch_valid,
    output logic [`RTN_CH_NUM-1:0][$clog2(`RTN_BANK_NUM)-1:0] ch_bank,
    output rsp_op_e [`RTN_CH_NUM-1:0]                        ch_op,
    output logic [`RTN_CH_NUM-1:0][`RTN_DATA_W-1:0]          ch_data
);

    rtn_head_if u_head_if ();

    // ==================================================
    // Buffer side
    // ==================================================
    rtn_xbar_entry_ram u_entry_ram (
        .clk            (clk),
        .rst_n          (rst_n),
        .bank_rsp_valid (bank_rsp_valid),
        .bank_rsp_ready (bank_rsp_ready),
        .bank_rsp_op    (bank_rsp_op),
        .bank_rsp_data  (bank_rsp_data),
        .head_bus       (u_head_if.provider)
    );

    rtn_xbar_ptr_gen u_ptr_gen (
        .clk            (clk),
        .rst_n          (rst_n),
        .bank_rsp_valid (bank_rsp_valid),
        .bank_rsp_ready (bank_rsp_ready),
        .head_bus       (u_head_if.provider)
    );

    // ==================================================
    // Delivery side
    // ==================================================
    rtn_xbar_ch_deliver u_ch_deliver (
        .clk            (clk),
        .rst_n          (rst_n),
        .ch_stall       (ch_stall),
        .head_bus       (u_head_if.consumer),
        .ch_valid       (ch_valid),
        .ch_bank        (ch_bank),
        .ch_op          (ch_op),
        .ch_data        (ch_data)
    );

endmodule

/* verif/rtn_xbar_assert.sv */
`timescale 1ns/1ps
`include "rtn_xbar_consts.svh"

module rtn_xbar_assert (
    input  logic                                             clk,
    input  logic                                             rst_n,
    input  logic [`RTN_BANK_NUM-1:0]                         bank_rsp_ready,
    input  logic [`RTN_CH_NUM-1:0]                           ch_valid,
    input  logic [`RTN_CH_NUM-1:0][$clog2(`RTN_BANK_NUM)-1:0] ch_bank,
    input  logic [`RTN_BANK_NUM-1:0][`RTN_PTR_W-1:0]         w_ptr,
    input  logic [`RTN_BANK_NUM-1:0][`RTN_PTR_W-1:0]         r_ptr,
    input  logic [`RTN_BANK_NUM-1:0][`RTN_CH_NUM-1:0]        pop_done
);

    logic [`RTN_BANK_NUM-1:0][`RTN_PTR_W-1:0]  occ;
    logic [`RTN_BANK_NUM-1:0][`RTN_CH_NUM-1:0] pop_done_q;

    // Count of failed assertions
    int fail_cnt = 0;

    // Flags as seen by the choice behind the current strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pop_done_q <= '0;
        end else begin
            pop_done_q <= pop_done;
        end
    end

    // ==================================================
    // Per-bank checks
    // ==================================================
    for (genvar b = 0; b < `RTN_BANK_NUM; b++) begin : g_bank
        // Pointer distance equals occupancy, at most seven
        assign occ[b] = w_ptr[b] - r_ptr[b];

        a_ready_with_room: assert property (@(posedge clk) disable iff (!rst_n)
            (occ[b] < (`RTN_DEPTH - 1)) |-> bank_rsp_ready[b])
            else begin
                fail_cnt++;
                $error("bank %0d ready low with room in its ring", b);
            end

        a_rptr_idle: assert property (@(posedge clk) disable iff (!rst_n)
            (occ[b] == '0) |=> $stable(r_ptr[b]))
            else begin
                fail_cnt++;
                $error("bank %0d read pointer moved while empty", b);
            end
    end

    for (genvar c = 0; c < `RTN_CH_NUM; c++) begin : g_ch
        a_no_repeat: assert property (@(posedge clk) disable iff (!rst_n)
            ch_valid[c] |-> !pop_done_q[ch_bank[c]][c])
            else begin
                fail_cnt++;
                $error("channel %0d took a head it already had", c);
            end
    end

endmodule

bind rtn_xbar rtn_xbar_assert u_rtn_xbar_assert (
    .clk            (clk),
    .rst_n          (rst_n),
    .bank_rsp_ready (bank_rsp_ready),
    .ch_valid       (ch_valid),
    .ch_bank        (ch_bank),
    .w_ptr          (u_head_if.w_ptr),
    .r_ptr          (u_head_if.r_ptr),
    .pop_done       (u_head_if.pop_done)
);

/* verif/rtn_xbar_tb.sv */
`timescale 1ns/1ps
`include "rtn_xbar_consts.svh"

module rtn_xbar_tb
    import rtn_xbar_pkg::*;
();

    localparam int NUM_ROWS = 6;

    typedef struct {
        logic [`RTN_BANK_NUM-1:0] mask;
        rsp_op_e                  op;
        logic [`RTN_DATA_W-1:0]   base;
        int                       count;
        logic [`RTN_CH_NUM-1:0]   stall;
    } row_t;

    logic                                              clk;
    logic                                              rst_n;
    logic [`RTN_BANK_NUM-1:0]                          bank_rsp_valid;
    logic [`RTN_BANK_NUM-1:0]                          bank_rsp_ready;
    rsp_op_e [`RTN_BANK_NUM-1:0]                       bank_rsp_op;
    logic [`RTN_BANK_NUM-1:0][`RTN_DATA_W-1:0]         bank_rsp_data;
    logic [`RTN_CH_NUM-1:0]                            ch_stall;
    logic [`RTN_CH_NUM-1:0]                            ch_valid;
    logic [`RTN_CH_NUM-1:0][$clog2(`RTN_BANK_NUM)-1:0] ch_bank;
    rsp_op_e [`RTN_CH_NUM-1:0]                         ch_op;
    logic [`RTN_CH_NUM-1:0][`RTN_DATA_W-1:0]           ch_data;

    row_t        rows [NUM_ROWS];
    logic [15:0] lfsr;
    int          cycles;
    int          limit;

    // Reference queues, one write count per bank and one read count per channel
    rtn_rsp_t exp_q [`RTN_BANK_NUM][256];
    int       w_cnt [`RTN_BANK_NUM];
    int       r_cnt [`RTN_BANK_NUM];
    int       d_cnt [`RTN_BANK_NUM][`RTN_CH_NUM];
    logic     took  [`RTN_BANK_NUM];
    logic     pend  [`RTN_CH_NUM][`RTN_BANK_NUM];
    logic     owe   [`RTN_CH_NUM][`RTN_BANK_NUM][`RTN_BANK_NUM];

    rtn_xbar u_rtn_xbar (
        .clk            (clk),
        .rst_n          (rst_n),
        .bank_rsp_valid (bank_rsp_valid),
        .bank_rsp_ready (bank_rsp_ready),
        .bank_rsp_op    (bank_rsp_op),
        .bank_rsp_data  (bank_rsp_data),
        .ch_stall       (ch_stall),
        .ch_valid       (ch_valid),
        .ch_bank        (ch_bank),
        .ch_op          (ch_op),
        .ch_data        (ch_data)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // ==================================================
    // Helpers
    // ==================================================
    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "stopped on first failure");
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("error at %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
            abort_run();
        end
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[14:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    function automatic logic drained();
        for (int b = 0; b < `RTN_BANK_NUM; b++) begin
            for (int c = 0; c < `RTN_CH_NUM; c++) begin
                if (d_cnt[b][c] != w_cnt[b]) begin
                    return 1'b0;
                end
            end
        end
        return 1'b1;
    endfunction

    // ==================================================
    // Monitor and scoreboard
    // ==================================================
    always @(posedge clk) begin : monitor
        int   bk;
        logic all_taken;

        if (rst_n) begin
            // Strobes seen here were chosen at the previous edge
            for (int c = 0; c < `RTN_CH_NUM; c++) begin
                if (ch_valid[c]) begin
                    bk = ch_bank[c];
                    check(d_cnt[bk][c] < w_cnt[bk], 1'b1,
                          $sformatf("channel %0d strobe for empty bank %0d", c, bk));
                    check({ch_op[c], ch_data[c]}, exp_q[bk][d_cnt[bk][c]],
                          $sformatf("channel %0d bank %0d response", c, bk));
                    for (int o = 0; o < `RTN_BANK_NUM; o++) begin
                        check(owe[c][bk][o], 1'b0,
                              $sformatf("channel %0d bank %0d served before bank %0d", c, bk, o));
                    end
                    for (int o = 0; o < `RTN_BANK_NUM; o++) begin
                        owe[c][o][bk] = 1'b0;
                        owe[c][bk][o] = (o != bk) && pend[c][o];
                    end
                    d_cnt[bk][c]++;
                end
            end
            // Pending view for the choice made at this edge
            for (int b = 0; b < `RTN_BANK_NUM; b++) begin
                for (int c = 0; c < `RTN_CH_NUM; c++) begin
                    pend[c][b] = (w_cnt[b] > r_cnt[b]) && (d_cnt[b][c] == r_cnt[b]);
                end
            end
            for (int b = 0; b < `RTN_BANK_NUM; b++) begin
                all_taken = 1'b1;
                for (int c = 0; c < `RTN_CH_NUM; c++) begin
                    if (d_cnt[b][c] <= r_cnt[b]) begin
                        all_taken = 1'b0;
                    end
                end
                if (all_taken) begin
                    r_cnt[b]++;
                end
                if (bank_rsp_valid[b] && bank_rsp_ready[b]) begin
                    exp_q[b][w_cnt[b]] = '{op: bank_rsp_op[b], data: bank_rsp_data[b]};
                    w_cnt[b]++;
                    took[b] = 1'b1;
                end
            end
        end
    end

    // Cycle limit and bound checker watch
    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: run exceeded %0d cycles before all tests finished", limit);
            abort_run();
        end else if (u_rtn_xbar.u_rtn_xbar_assert.fail_cnt != 0) begin
            $display("a bound assertion on the crossbar failed");
            abort_run();
        end
    end

    // ==================================================
    // Stimulus
    // ==================================================
    task automatic run_row(input int r);
        int          sent [`RTN_BANK_NUM];
        logic        saw_full;
        logic        done;
        logic [15:0] noise;

        saw_full = 1'b0;
        done     = 1'b0;
        for (int b = 0; b < `RTN_BANK_NUM; b++) begin
            sent[b] = 0;
        end
        ch_stall = rows[r].stall;
        while (!done) begin
            @(negedge clk);
            for (int b = 0; b < `RTN_BANK_NUM; b++) begin
                if (took[b]) begin
                    took[b]           = 1'b0;
                    bank_rsp_valid[b] = 1'b0;
                    sent[b]++;
                end
            end
            // A stalled channel holds every head until the ring is full
            if (ch_stall != '0) begin
                for (int b = 0; b < `RTN_BANK_NUM; b++) begin
                    if (rows[r].mask[b] && sent[b] < rows[r].count && !bank_rsp_ready[b]) begin
                        check(sent[b], `RTN_DEPTH - 1, $sformatf("bank %0d accepted", b));
                        saw_full = 1'b1;
                    end
                end
                if (saw_full) begin
                    ch_stall = '0;
                end
            end
            done = 1'b1;
            for (int b = 0; b < `RTN_BANK_NUM; b++) begin
                if (rows[r].mask[b] && sent[b] < rows[r].count) begin
                    done = 1'b0;
                    if (!bank_rsp_valid[b] && take_bits(1)) begin
                        noise             = take_bits(16);
                        bank_rsp_valid[b] = 1'b1;
                        bank_rsp_op[b]    = rows[r].op;
                        bank_rsp_data[b]  = rows[r].base ^ noise;
                    end
                end
            end
        end
        ch_stall = '0;
        check(saw_full, (rows[r].stall != '0) && (rows[r].count > `RTN_DEPTH - 1),
              $sformatf("row %0d ready dropped under stall", r));
        while (!drained()) begin
            @(negedge clk);
        end
    endtask

    initial begin : main
        int exp_total [`RTN_BANK_NUM];

        rows[0] = '{4'b1111, RSP_RD_DATA, 16'h1000, 1, 3'b000};
        rows[1] = '{4'b0101, RSP_WR_ACK, 16'h2000, 3, 3'b000};
        rows[2] = '{4'b1111, RSP_RD_DATA, 16'h3000, 12, 3'b000};
        rows[3] = '{4'b0100, RSP_ERR, 16'h4000, 10, 3'b001};
        rows[4] = '{4'b1111, RSP_WR_ACK, 16'h5000, 20, 3'b000};
        rows[5] = '{4'b1010, RSP_RD_DATA, 16'h6000, 8, 3'b110};

        lfsr    = 16'd40888;
        cycles  = 0;
        limit   = 200;
        for (int r = 0; r < NUM_ROWS; r++) begin
            limit += rows[r].count * 24;
        end

        rst_n          = 1'b0;
        bank_rsp_valid = '0;
        bank_rsp_data  = '0;
        ch_stall       = '0;
        for (int b = 0; b < `RTN_BANK_NUM; b++) begin
            bank_rsp_op[b] = RSP_RD_DATA;
            w_cnt[b]       = 0;
            r_cnt[b]       = 0;
            took[b]        = 1'b0;
            exp_total[b]   = 0;
            for (int c = 0; c < `RTN_CH_NUM; c++) begin
                d_cnt[b][c] = 0;
                pend[c][b]  = 1'b0;
                for (int o = 0; o < `RTN_BANK_NUM; o++) begin
                    owe[c][b][o] = 1'b0;
                end
            end
        end

        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check(bank_rsp_ready, {`RTN_BANK_NUM{1'b1}}, "ready after reset");
        check(ch_valid, '0, "ch_valid after reset");

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        // Quiet period to catch any stray strobe
        repeat (10) @(negedge clk);

        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int b = 0; b < `RTN_BANK_NUM; b++) begin
                if (rows[r].mask[b]) begin
                    exp_total[b] += rows[r].count;
                end
            end
        end
        for (int b = 0; b < `RTN_BANK_NUM; b++) begin
            check(w_cnt[b], exp_total[b], $sformatf("bank %0d accepted total", b));
            for (int c = 0; c < `RTN_CH_NUM; c++) begin
                check(d_cnt[b][c], w_cnt[b], $sformatf("bank %0d channel %0d delivered", b, c));
            end
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* sources.f */
+incdir+rtl
rtl/rtn_xbar_pkg.sv
rtl/rtn_head_if.sv
rtl/rtn_xbar_entry_ram.sv
rtl/rtn_xbar_ptr_gen.sv
rtl/rtn_xbar_ch_deliver.sv
rtl/rtn_xbar.sv
verif/rtn_xbar_assert.sv
verif/rtn_xbar_tb.sv
